// ==== source/soc_xbar_pkg.sv ====
`default_nettype none

package soc_xbar_pkg;

    //////////////////////////////
    // Widths and sizes
    //////////////////////////////
    localparam int unsigned ADDR_W        = 32;
    localparam int unsigned DATA_W        = 32;
    localparam int unsigned BE_W          = 4;
    localparam int unsigned BYTE_W        = DATA_W / BE_W;
    localparam int unsigned NR_L2_BANKS   = 4;
    localparam int unsigned L2_BANK_WORDS = 256;
    localparam int unsigned FIFO_DEPTH    = 2;

    // Bank index sits right above the byte offset, row above the bank index
    localparam int unsigned L2_BANK_W   = $clog2(NR_L2_BANKS);
    localparam int unsigned L2_ROW_W    = $clog2(L2_BANK_WORDS);
    localparam int unsigned L2_BANK_LSB = $clog2(BE_W);
    localparam int unsigned L2_ROW_LSB  = L2_BANK_LSB + L2_BANK_W;

    //////////////////////////////
    // Address map
    //////////////////////////////
    localparam logic [ADDR_W-1:0] L2_START     = 32'h1C00_0000;
    localparam logic [ADDR_W-1:0] L2_END       = 32'h1C00_0FFF;
    localparam logic [ADDR_W-1:0] PERIPH_START = 32'h1A10_0000;
    localparam logic [ADDR_W-1:0] PERIPH_END   = 32'h1A1F_FFFF;

    // Legacy alias of the top address field
    localparam int unsigned       PREFIX_W     = 12;
    localparam logic [PREFIX_W-1:0] ALIAS_PREFIX = 12'h000;
    localparam logic [PREFIX_W-1:0] L2_PREFIX    = 12'h1C0;

    // APB wait bound in ACCESS cycles
    localparam int unsigned APB_TIMEOUT_CYCLES = 16;
    localparam int unsigned TMO_CNT_W          = $clog2(APB_TIMEOUT_CYCLES + 1);

    //////////////////////////////
    // Types
    //////////////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
        logic              we;
    } xbar_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } xbar_rsp_t;

    typedef enum logic [1:0] {
        TGT_L2     = 2'd0,
        TGT_PERIPH = 2'd1,
        TGT_NONE   = 2'd2
    } target_e;

    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [L2_BANK_W-1:0] bank;
        logic [L2_ROW_W-1:0]  row;
        logic [DATA_W-1:0]    wdata;
        logic [BE_W-1:0]      be;
        logic                 we;
        logic                 en;
    } l2_req_t;

endpackage

`default_nettype wire

// ==== source/stream_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = soc_xbar_pkg::FIFO_DEPTH
) (
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire payload_t in_i,
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    output payload_t      out_o,
    output logic          out_valid_o,
    input  wire logic     out_ready_i
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    payload_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // Full blocks the writer, empty hides the head
    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;
    assign out_o       = mem_q[rd_ptr_q];

    // Pointers wrap at DEPTH
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the fill level unchanged
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/addr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module addr_decoder (
    input  wire soc_xbar_pkg::xbar_req_t req_i,
    output soc_xbar_pkg::xbar_req_t      req_o,
    output soc_xbar_pkg::target_e        target_o
);

    localparam int unsigned PFX_LSB = soc_xbar_pkg::ADDR_W - soc_xbar_pkg::PREFIX_W;

    logic [soc_xbar_pkg::ADDR_W-1:0] addr;

    //////////////////////////////
    // Legacy alias remap
    //////////////////////////////
    // A zero top field is the old L2 alias, e.g. 0x00000123 -> 0x1C000123
    always_comb begin
        req_o = req_i;
        if (req_i.addr[soc_xbar_pkg::ADDR_W-1:PFX_LSB] == soc_xbar_pkg::ALIAS_PREFIX) begin
            req_o.addr[soc_xbar_pkg::ADDR_W-1:PFX_LSB] = soc_xbar_pkg::L2_PREFIX;
        end
    end

    assign addr = req_o.addr;

    //////////////////////////////
    // Region decode
    //////////////////////////////
    // Decode runs on the remapped address
    always_comb begin
        if (addr >= soc_xbar_pkg::L2_START && addr <= soc_xbar_pkg::L2_END) begin
            target_o = soc_xbar_pkg::TGT_L2;
        end else if (addr >= soc_xbar_pkg::PERIPH_START && addr <= soc_xbar_pkg::PERIPH_END) begin
            target_o = soc_xbar_pkg::TGT_PERIPH;
        end else begin
            // Unmapped, answered with an error
            target_o = soc_xbar_pkg::TGT_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== source/l2_bank_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_bank_array (
    input  wire logic                      clk_i,
    input  wire soc_xbar_pkg::l2_req_t     l2_i,
    output logic [soc_xbar_pkg::DATA_W-1:0] rdata_o
);

    localparam int unsigned NB     = soc_xbar_pkg::NR_L2_BANKS;
    localparam int unsigned BYTE_W = soc_xbar_pkg::BYTE_W;

    // Read register of each bank
    logic [soc_xbar_pkg::DATA_W-1:0]    bank_rdata_q [NB];
    // Bank of the last read, steers the output mux
    logic [soc_xbar_pkg::L2_BANK_W-1:0] rd_bank_q;

    for (genvar b = 0; b < NB; b++) begin : g_bank
        logic [soc_xbar_pkg::DATA_W-1:0] mem_q [soc_xbar_pkg::L2_BANK_WORDS];
        logic                            sel;

        assign sel = l2_i.en && (l2_i.bank == soc_xbar_pkg::L2_BANK_W'(b));

        always_ff @(posedge clk_i) begin
            if (sel && l2_i.we) begin
                // Only enabled byte lanes are written
                for (int i = 0; i < soc_xbar_pkg::BE_W; i++) begin
                    if (l2_i.be[i]) begin
                        mem_q[l2_i.row][i*BYTE_W +: BYTE_W] <= l2_i.wdata[i*BYTE_W +: BYTE_W];
                    end
                end
            end else if (sel) begin
                bank_rdata_q[b] <= mem_q[l2_i.row];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (l2_i.en && !l2_i.we) begin
            rd_bank_q <= l2_i.bank;
        end
    end

    // Data holds until the next read
    assign rdata_o = bank_rdata_q[rd_bank_q];

endmodule

`default_nettype wire

// ==== source/apb_timeout_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_timeout_counter (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic enable_i,
    input  wire logic clear_i,
    output logic      expired_o
);

    localparam int unsigned CNT_W = soc_xbar_pkg::TMO_CNT_W;
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(soc_xbar_pkg::APB_TIMEOUT_CYCLES);

    logic [CNT_W-1:0] count_q;

    // Clear wins over enable, count stops at the limit
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            count_q <= '0;
        end else if (enable_i && count_q != LIMIT) begin
            count_q <= count_q + 1'b1;
        end
    end

    // High as soon as the count reaches the limit
    assign expired_o = (count_q == LIMIT);

endmodule

`default_nettype wire

// ==== source/xbar_ctrl_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module xbar_ctrl_fsm (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire soc_xbar_pkg::xbar_req_t     req_i,
    input  wire soc_xbar_pkg::target_e       target_i,
    input  wire logic                        req_valid_i,
    output logic                             req_ready_o,
    output soc_xbar_pkg::l2_req_t            l2_o,
    input  wire logic [soc_xbar_pkg::DATA_W-1:0] l2_rdata_i,
    output soc_xbar_pkg::apb_req_t           apb_o,
    input  wire soc_xbar_pkg::apb_rsp_t      apb_i,
    output logic                             tmo_enable_o,
    output logic                             tmo_clear_o,
    input  wire logic                        tmo_expired_i,
    output soc_xbar_pkg::xbar_rsp_t          rsp_o,
    output logic                             rsp_valid_o,
    input  wire logic                        rsp_ready_i
);

    typedef enum logic [2:0] {
        IDLE,
        L2_ACCESS,
        APB_SETUP,
        APB_ACCESS,
        RESP
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    soc_xbar_pkg::xbar_req_t req_q;
    soc_xbar_pkg::xbar_rsp_t rsp_q;
    // Response data comes straight from the banks
    logic                    from_l2_q;
    logic                    pop;

    assign req_ready_o = (state_q == IDLE);
    assign pop         = req_valid_i && req_ready_o;

    //////////////////////////////
    // Next state
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    case (target_i)
                        soc_xbar_pkg::TGT_L2:     state_d = L2_ACCESS;
                        soc_xbar_pkg::TGT_PERIPH: state_d = APB_SETUP;
                        default:                  state_d = RESP;
                    endcase
                end
            end
            L2_ACCESS: state_d = RESP;
            APB_SETUP: state_d = APB_ACCESS;
            APB_ACCESS: begin
                if (apb_i.pready || tmo_expired_i) begin
                    state_d = RESP;
                end
            end
            // Wait here while the response FIFO is full
            RESP: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= IDLE;
            from_l2_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (pop) begin
                from_l2_q <= (target_i == soc_xbar_pkg::TGT_L2);
            end
        end
    end

    //////////////////////////////
    // Request and response hold
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (pop) begin
            req_q       <= req_i;
            rsp_q.rdata <= '0;
            // Unmapped requests fail at once
            rsp_q.err   <= (target_i == soc_xbar_pkg::TGT_NONE);
        end else if (state_q == APB_ACCESS) begin
            if (apb_i.pready) begin
                // Reads with an error and all writes return zero data
                rsp_q.rdata <= (req_q.we || apb_i.pslverr) ? '0 : apb_i.prdata;
                rsp_q.err   <= apb_i.pslverr;
            end else if (tmo_expired_i) begin
                rsp_q.rdata <= '0;
                rsp_q.err   <= 1'b1;
            end
        end
    end

    // L2 read data arrives one cycle after the bank access
    always_comb begin
        rsp_o = rsp_q;
        if (from_l2_q && !req_q.we) begin
            rsp_o.rdata = l2_rdata_i;
        end
    end

    assign rsp_valid_o = (state_q == RESP);

    //////////////////////////////
    // L2 bank access
    //////////////////////////////
    assign l2_o.bank  = req_q.addr[soc_xbar_pkg::L2_BANK_LSB +: soc_xbar_pkg::L2_BANK_W];
    assign l2_o.row   = req_q.addr[soc_xbar_pkg::L2_ROW_LSB +: soc_xbar_pkg::L2_ROW_W];
    assign l2_o.wdata = req_q.wdata;
    assign l2_o.be    = req_q.be;
    assign l2_o.we    = req_q.we;
    assign l2_o.en    = (state_q == L2_ACCESS);

    //////////////////////////////
    // APB phases
    //////////////////////////////
    assign apb_o.paddr   = req_q.addr;
    assign apb_o.psel    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
    assign apb_o.penable = (state_q == APB_ACCESS);
    assign apb_o.pwrite  = req_q.we;
    assign apb_o.pwdata  = req_q.wdata;

    // Timer runs only in ACCESS and restarts otherwise
    assign tmo_enable_o = (state_q == APB_ACCESS);
    assign tmo_clear_o  = (state_q != APB_ACCESS);

endmodule

`default_nettype wire

// ==== source/soc_xbar_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_xbar_top (
    input  wire logic                    clk_i,
    input  wire logic                    reset_i,
    input  wire soc_xbar_pkg::xbar_req_t req_i,
    input  wire logic                    req_valid_i,
    output logic                         req_ready_o,
    output soc_xbar_pkg::xbar_rsp_t      rsp_o,
    output logic                         rsp_valid_o,
    input  wire logic                    rsp_ready_i,
    output soc_xbar_pkg::apb_req_t       apb_o,
    input  wire soc_xbar_pkg::apb_rsp_t  apb_i
);

    // Request FIFO head
    soc_xbar_pkg::xbar_req_t         head_req;
    logic                            head_valid;
    logic                            head_ready;
    // Decoded head
    soc_xbar_pkg::xbar_req_t         dec_req;
    soc_xbar_pkg::target_e           dec_target;
    // Bank port
    soc_xbar_pkg::l2_req_t           l2_req;
    logic [soc_xbar_pkg::DATA_W-1:0] l2_rdata;
    // Timeout counter
    logic                            tmo_enable;
    logic                            tmo_clear;
    logic                            tmo_expired;
    // Response FIFO input
    soc_xbar_pkg::xbar_rsp_t         fsm_rsp;
    logic                            fsm_rsp_valid;
    logic                            fsm_rsp_ready;

    //////////////////////////////
    // Request path
    //////////////////////////////
    stream_fifo #(
        .payload_t (soc_xbar_pkg::xbar_req_t)
    ) i_req_fifo (
        .clk_i,
        .reset_i,
        .in_i        (req_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .out_o       (head_req),
        .out_valid_o (head_valid),
        .out_ready_i (head_ready)
    );

    addr_decoder i_addr_decoder (
        .req_i    (head_req),
        .req_o    (dec_req),
        .target_o (dec_target)
    );

    xbar_ctrl_fsm i_ctrl (
        .clk_i,
        .reset_i,
        .req_i         (dec_req),
        .target_i      (dec_target),
        .req_valid_i   (head_valid),
        .req_ready_o   (head_ready),
        .l2_o          (l2_req),
        .l2_rdata_i    (l2_rdata),
        .apb_o         (apb_o),
        .apb_i         (apb_i),
        .tmo_enable_o  (tmo_enable),
        .tmo_clear_o   (tmo_clear),
        .tmo_expired_i (tmo_expired),
        .rsp_o         (fsm_rsp),
        .rsp_valid_o   (fsm_rsp_valid),
        .rsp_ready_i   (fsm_rsp_ready)
    );

    //////////////////////////////
    // Targets
    //////////////////////////////
    l2_bank_array i_l2 (
        .clk_i,
        .l2_i    (l2_req),
        .rdata_o (l2_rdata)
    );

    apb_timeout_counter i_apb_tmo (
        .clk_i,
        .reset_i,
        .enable_i  (tmo_enable),
        .clear_i   (tmo_clear),
        .expired_o (tmo_expired)
    );

    // Responses leave in request order
    stream_fifo #(
        .payload_t (soc_xbar_pkg::xbar_rsp_t)
    ) i_rsp_fifo (
        .clk_i,
        .reset_i,
        .in_i        (fsm_rsp),
        .in_valid_i  (fsm_rsp_valid),
        .in_ready_o  (fsm_rsp_ready),
        .out_o       (rsp_o),
        .out_valid_o (rsp_valid_o),
        .out_ready_i (rsp_ready_i)
    );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset drops on a falling edge after the last reset cycle
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/soc_xbar_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_xbar_chk (
    input wire logic                    clk_i,
    input wire logic                    reset_i,
    input wire soc_xbar_pkg::xbar_req_t req_i,
    input wire logic                    req_valid_i,
    input wire logic                    req_ready_i,
    input wire soc_xbar_pkg::xbar_rsp_t rsp_i,
    input wire logic                    rsp_valid_i,
    input wire logic                    rsp_ready_i,
    input wire soc_xbar_pkg::apb_req_t  apb_i
);

    // One SETUP cycle plus the ACCESS cycles up to the expired flag
    localparam int unsigned PSEL_MAX = soc_xbar_pkg::APB_TIMEOUT_CYCLES + 2;

    // Count of failed assertions
    int unsigned err_cnt = 0;
    logic        psel;
    logic        penable;

    assign psel    = apb_i.psel;
    assign penable = apb_i.penable;

    //////////////////////////////
    // APB phases
    //////////////////////////////
    a_setup_once: assert property (@(posedge clk_i) disable iff (reset_i)
        (psel && !penable) |=> (psel && penable))
        else begin
            err_cnt++;
            $error("APB SETUP phase did not last exactly one cycle");
        end

    a_enable_sel: assert property (@(posedge clk_i) disable iff (reset_i)
        penable |-> psel)
        else begin
            err_cnt++;
            $error("APB penable high without psel");
        end

    // Bounded by the timeout counter
    a_psel_bound: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(psel) |-> ##[1:PSEL_MAX] !psel)
        else begin
            err_cnt++;
            $error("APB psel stayed high past the timeout bound");
        end

    //////////////////////////////
    // Stream stability
    //////////////////////////////
    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (req_valid_i && !req_ready_i) |=> (req_valid_i && $stable(req_i)))
        else begin
            err_cnt++;
            $error("Request changed while waiting for ready");
        end

    a_rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
        else begin
            err_cnt++;
            $error("Response changed while waiting for ready");
        end

endmodule

bind soc_xbar_top soc_xbar_chk i_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .rsp_i       (rsp_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .apb_i       (apb_o)
);

`default_nettype wire

// ==== test/soc_xbar_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_xbar_tb;

    localparam int unsigned CLK_PERIOD   = 20;
    localparam int unsigned L2_WORDS     = soc_xbar_pkg::NR_L2_BANKS
                                           * soc_xbar_pkg::L2_BANK_WORDS;
    localparam int unsigned N_L2         = 16;
    localparam int unsigned N_APB        = 12;
    localparam int unsigned N_BP         = 24;
    localparam int unsigned N_TESTS      = 3 * N_L2 + 4 + 2 * N_APB + 6 + N_BP;
    // Slave model wait states and register file
    localparam int unsigned APB_MAX_WAIT = 4;
    localparam int unsigned APB_REGS     = 64;
    // A timed out APB access plus FIFO and FSM overhead
    localparam int unsigned WORST_CYCLES = soc_xbar_pkg::APB_TIMEOUT_CYCLES + 8;
    localparam longint unsigned WATCHDOG_NS =
        64'(N_TESTS) * WORST_CYCLES * 2 * CLK_PERIOD + 200 * CLK_PERIOD;

    // Reserved peripheral addresses and two unmapped ones
    localparam logic [31:0] TMO_ADDR    = 32'h1A1F_F000;
    localparam logic [31:0] SLVERR_ADDR = 32'h1A1F_F004;
    localparam logic [31:0] UNMAP_ADDR0 = 32'h3000_0000;
    localparam logic [31:0] UNMAP_ADDR1 = 32'h1C00_1000;

    logic                    clk;
    logic                    reset;
    soc_xbar_pkg::xbar_req_t req;
    logic                    req_valid;
    logic                    req_ready;
    soc_xbar_pkg::xbar_rsp_t rsp;
    logic                    rsp_valid;
    logic                    rsp_ready = 1'b0;
    soc_xbar_pkg::apb_req_t  apb_req;
    soc_xbar_pkg::apb_rsp_t  apb_rsp = '0;

    integer      seed = 99;
    logic        bp_en = 1'b0;
    int unsigned setup_cnt = 0;
    int unsigned apb_wait = 0;

    // Reference models
    logic [31:0] l2_model [L2_WORDS];
    logic [31:0] apb_exp [APB_REGS];
    logic [31:0] apb_mem [APB_REGS];
    int          l2_idx_q [$];

    // Expected responses in request order
    soc_xbar_pkg::xbar_rsp_t exp_q [$];
    string                   name_q [$];

    tb_clk_gen #(
        .PERIOD_NS (CLK_PERIOD)
    ) i_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    soc_xbar_top dut0 (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .apb_o       (apb_req),
        .apb_i       (apb_rsp)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic error_abort(input string msg);
        $display("ERROR: %s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic mismatch_abort(input string name, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s: %s expected %h actual %h", name, what, exp, act);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on mismatch");
    endtask

    // Enabled byte lanes take the new data
    function automatic logic [31:0] merge_be(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0] be);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] l2_addr(input int idx);
        return soc_xbar_pkg::L2_START + 32'(idx) * 4;
    endfunction

    function automatic logic [31:0] apb_fill(input int idx);
        return (soc_xbar_pkg::PERIPH_START + 32'(idx) * 4) ^ 32'h5A5A_C3C3;
    endfunction

    task automatic send_req(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, input logic we,
                            input logic [31:0] exp_rdata, input logic exp_err,
                            input string name);
        soc_xbar_pkg::xbar_rsp_t exp;
        logic                    accepted;
        exp.rdata = exp_rdata;
        exp.err   = exp_err;
        exp_q.push_back(exp);
        name_q.push_back(name);
        req.addr  = addr;
        req.wdata = wdata;
        req.be    = be;
        req.we    = we;
        req_valid = 1'b1;
        // Ready seen between edges decides the next rising edge
        accepted = 1'b0;
        while (!accepted) begin
            accepted = req_ready;
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic l2_access(input logic [31:0] addr, input logic we,
                             input logic [31:0] wdata, input logic [3:0] be,
                             input string name);
        logic [31:0] exp_rdata;
        int          idx;
        // Aliased and direct L2 addresses share the word offset
        idx  = int'(addr[11:2]);
        exp_rdata = '0;
        if (we) begin
            l2_model[idx] = merge_be(l2_model[idx], wdata, be);
        end else begin
            exp_rdata = l2_model[idx];
        end
        send_req(addr, wdata, be, we, exp_rdata, 1'b0, name);
    endtask

    task automatic apb_access(input int idx, input logic we, input logic [31:0] wdata,
                              input string name);
        logic [31:0] exp_rdata;
        exp_rdata = '0;
        if (we) begin
            apb_exp[idx] = wdata;
        end else begin
            exp_rdata = apb_exp[idx];
        end
        send_req(soc_xbar_pkg::PERIPH_START + 32'(idx) * 4, wdata, 4'hF, we,
                 exp_rdata, 1'b0, name);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Response side
    //////////////////////////////
    // Ready is mostly low under back-pressure so both FIFOs fill
    always @(negedge clk) begin
        soc_xbar_pkg::xbar_rsp_t exp;
        string                   name;
        if (bp_en) begin
            rsp_ready = ($random(seed) & 7) == 0;
        end else begin
            rsp_ready = 1'b1;
        end
        if (rsp_valid && rsp_ready) begin
            assert (exp_q.size() != 0)
                else error_abort("Response arrived with no request outstanding");
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            assert (rsp.rdata === exp.rdata) else mismatch_abort(name, "rdata", exp.rdata,
                                                                  rsp.rdata);
            assert (rsp.err === exp.err) else mismatch_abort(name, "err", 32'(exp.err),
                                                              32'(rsp.err));
        end
    end

    // Checker assertions end the run on their first failure
    always @(negedge clk) begin
        if (dut0.i_chk.err_cnt != 0) begin
            error_abort("Protocol assertion failed in the checker");
        end
    end

    // APB slave model
    always @(negedge clk) begin
        int idx;
        idx = int'(apb_req.paddr[7:2]);
        if (reset || !apb_req.psel) begin
            apb_rsp = '0;
        end else if (!apb_req.penable) begin
            // Wait states picked in SETUP
            apb_wait = {$random(seed)} % (APB_MAX_WAIT + 1);
            setup_cnt++;
            apb_rsp = '0;
        end else if (apb_req.paddr == TMO_ADDR) begin
            apb_rsp = '0;
        end else if (apb_wait != 0) begin
            apb_wait--;
        end else if (apb_req.paddr == SLVERR_ADDR) begin
            // Junk data that the DUT must not pass on
            apb_rsp.prdata  = 32'hBAD0_0BAD;
            apb_rsp.pready  = 1'b1;
            apb_rsp.pslverr = 1'b1;
        end else begin
            apb_rsp.pready  = 1'b1;
            apb_rsp.pslverr = 1'b0;
            apb_rsp.prdata  = '0;
            if (apb_req.pwrite) begin
                apb_mem[idx] = apb_req.pwdata;
            end else begin
                apb_rsp.prdata = apb_mem[idx];
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        int          idx;
        int          base;
        int unsigned setup_before;
        logic [31:0] data;
        req       = '0;
        req_valid = 1'b0;
        for (int i = 0; i < APB_REGS; i++) begin
            apb_mem[i] = apb_fill(i);
            apb_exp[i] = apb_fill(i);
        end
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end

        // Eight consecutive words cover every bank twice
        base = ({$random(seed)} % (L2_WORDS / 8)) * 8;
        for (int i = 0; i < 8; i++) begin
            data = {8'(i), 24'($random(seed))};
            l2_idx_q.push_back(base + i);
            l2_access(l2_addr(base + i), 1'b1, data, 4'hF, "l2_rw");
        end
        for (int i = 8; i < N_L2; i++) begin
            idx = {$random(seed)} % L2_WORDS;
            l2_idx_q.push_back(idx);
            l2_access(l2_addr(idx), 1'b1, $random(seed), 4'hF, "l2_rw");
        end
        foreach (l2_idx_q[i]) begin
            l2_access(l2_addr(l2_idx_q[i]), 1'b1, $random(seed), 4'($random(seed)), "l2_be");
        end
        foreach (l2_idx_q[i]) begin
            l2_access(l2_addr(l2_idx_q[i]), 1'b0, '0, 4'hF, "l2_rd");
        end

        // Alias in both directions
        idx = {$random(seed)} % L2_WORDS;
        l2_access(l2_addr(idx), 1'b1, $random(seed), 4'hF, "alias_fwd");
        l2_access(l2_addr(idx) & 32'h000F_FFFF, 1'b0, '0, 4'hF, "alias_fwd");
        idx = {$random(seed)} % L2_WORDS;
        l2_access(l2_addr(idx) & 32'h000F_FFFF, 1'b1, $random(seed), 4'hF, "alias_rev");
        l2_access(l2_addr(idx), 1'b0, '0, 4'hF, "alias_rev");

        // Peripheral writes then reads
        for (int i = 0; i < N_APB; i++) begin
            apb_access({$random(seed)} % APB_REGS, 1'b1, $random(seed), "apb_wr");
        end
        for (int i = 0; i < N_APB; i++) begin
            apb_access({$random(seed)} % APB_REGS, 1'b0, '0, "apb_rd");
        end
        wait_drain();
        for (int i = 0; i < APB_REGS; i++) begin
            assert (apb_mem[i] === apb_exp[i])
                else mismatch_abort("apb_wr", "register", apb_exp[i], apb_mem[i]);
        end

        // Error responses
        send_req(TMO_ADDR, '0, 4'hF, 1'b0, '0, 1'b1, "apb_timeout");
        send_req(TMO_ADDR, $random(seed), 4'hF, 1'b1, '0, 1'b1, "apb_timeout");
        send_req(SLVERR_ADDR, '0, 4'hF, 1'b0, '0, 1'b1, "apb_slverr");
        send_req(SLVERR_ADDR, $random(seed), 4'hF, 1'b1, '0, 1'b1, "apb_slverr");
        wait_drain();
        setup_before = setup_cnt;
        send_req(UNMAP_ADDR0, '0, 4'hF, 1'b0, '0, 1'b1, "unmapped");
        send_req(UNMAP_ADDR1, $random(seed), 4'hF, 1'b1, '0, 1'b1, "unmapped");
        wait_drain();
        assert (setup_cnt == setup_before)
            else error_abort("Unmapped request started an APB transfer");

        // Back-pressure on a mixed stream
        bp_en = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            case (i % 3)
                0: begin
                    idx = {$random(seed)} % l2_idx_q.size();
                    l2_access(l2_addr(l2_idx_q[idx]), 1'b0, '0, 4'hF, "backpressure");
                end
                1: apb_access({$random(seed)} % APB_REGS, 1'b1, $random(seed), "backpressure");
                default: apb_access({$random(seed)} % APB_REGS, 1'b0, '0, "backpressure");
            endcase
        end
        wait_drain();
        bp_en = 1'b0;

        if (dut0.i_chk.err_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            error_abort("Protocol assertions fired in the checker");
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        error_abort("Watchdog expired, the DUT stopped responding");
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/soc_xbar_pkg.sv
source/stream_fifo.sv
source/addr_decoder.sv
source/l2_bank_array.sv
source/apb_timeout_counter.sv
source/xbar_ctrl_fsm.sv
source/soc_xbar_top.sv
test/tb_clk_gen.sv
test/soc_xbar_chk.sv
test/soc_xbar_tb.sv

// ==== Bender.yml ====
package:
  name: soc_xbar

sources:
  - source/soc_xbar_pkg.sv
  - source/stream_fifo.sv
  - source/addr_decoder.sv
  - source/l2_bank_array.sv
  - source/apb_timeout_counter.sv
  - source/xbar_ctrl_fsm.sv
  - source/soc_xbar_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/soc_xbar_chk.sv
      - test/soc_xbar_tb.sv
